// File: axi4s_if.sv
/*
 * Pixel stream interface in AXI4-Stream style.
 * Source and sink modports for one valid/ready channel.
 */

interface axi4s_if
    import trim_pkg::*;
#(
    parameter int DATA_BITS = DEF_DATA_BITS
);

    logic [DATA_BITS-1:0] tdata;
    logic                 tuser;   // first pixel of a frame.
    logic                 tlast;   // last pixel of a line.
    logic                 tvalid;
    logic                 tready;

    modport src (
        output tdata,
        output tuser,
        output tlast,
        output tvalid,
        input  tready
    );

    modport snk (
        input  tdata,
        input  tuser,
        input  tlast,
        input  tvalid,
        output tready
    );

endinterface

// File: image_trimming.sv
/*
 * Top level of the image cropping subsystem.
 * Plain stream and config ports, config block and the two crop stages.
 */

module image_trimming
    import trim_pkg::*;
#(
    parameter int COORD_BITS = DEF_COORD_BITS,
    parameter int DATA_BITS  = DEF_DATA_BITS
) (
    input  logic                  s_axi4s,
    input  logic                  rst_n,

    input  logic [DATA_BITS-1:0]  s_tdata,
    input  logic                  s_tuser,
    input  logic                  s_tlast,
    input  logic                  s_tvalid,
    output logic                  s_tready,

    output logic [DATA_BITS-1:0]  m_tdata,
    output logic                  m_tuser,
    output logic                  m_tlast,
    output logic                  m_tvalid,
    input  logic                  m_tready,

    input  logic                  cfg_req,
    input  trim_op_e              cfg_op,
    input  logic [COORD_BITS-1:0] cfg_data,
    output logic                  cfg_ack
);

    logic [COORD_BITS-1:0] x_start;
    logic [COORD_BITS-1:0] x_end;
    logic [COORD_BITS-1:0] y_start;
    logic [COORD_BITS-1:0] y_end;

    axi4s_if #(.DATA_BITS(DATA_BITS)) in_stream ();
    axi4s_if #(.DATA_BITS(DATA_BITS)) x_crop ();
    axi4s_if #(.DATA_BITS(DATA_BITS)) out_stream ();

    assign in_stream.tdata  = s_tdata;
    assign in_stream.tuser  = s_tuser;
    assign in_stream.tlast  = s_tlast;
    assign in_stream.tvalid = s_tvalid;
    assign s_tready         = in_stream.tready;

    assign m_tdata           = out_stream.tdata;
    assign m_tuser           = out_stream.tuser;
    assign m_tlast           = out_stream.tlast;
    assign m_tvalid          = out_stream.tvalid;
    assign out_stream.tready = m_tready;

    trim_config #(
        .COORD_BITS(COORD_BITS)
    ) u_config (
        .s_axi4s  (s_axi4s),
        .rst_n    (rst_n),
        .cfg_req  (cfg_req),
        .cfg_op   (cfg_op),
        .cfg_data (cfg_data),
        .cfg_ack  (cfg_ack),
        .x_start  (x_start),
        .x_end    (x_end),
        .y_start  (y_start),
        .y_end    (y_end)
    );

    line_trimming #(
        .COORD_BITS(COORD_BITS),
        .DATA_BITS (DATA_BITS)
    ) u_line (
        .s_axi4s  (s_axi4s),
        .rst_n    (rst_n),
        .x_start  (x_start),
        .x_end    (x_end),
        .s_stream (in_stream),
        .m_stream (x_crop)
    );

    row_trimming #(
        .COORD_BITS(COORD_BITS),
        .DATA_BITS (DATA_BITS)
    ) u_row (
        .s_axi4s  (s_axi4s),
        .rst_n    (rst_n),
        .y_start  (y_start),
        .y_end    (y_end),
        .s_stream (x_crop),
        .m_stream (out_stream)
    );

endmodule

// File: line_trimming.sv
/*
 * Horizontal crop stage.
 * Keeps columns x_start to x_end, forces tlast on the final kept pixel
 * and carries a dropped frame-start bit to the next kept pixel.
 */

module line_trimming
    import trim_pkg::*;
#(
    parameter int COORD_BITS = DEF_COORD_BITS,
    parameter int DATA_BITS  = DEF_DATA_BITS
) (
    input  logic                  s_axi4s,
    input  logic                  rst_n,
    input  logic [COORD_BITS-1:0] x_start,
    input  logic [COORD_BITS-1:0] x_end,
    axi4s_if.snk                  s_stream,
    axi4s_if.src                  m_stream
);

    logic [COORD_BITS-1:0] x_cnt;
    logic                  in_window;
    logic                  accept;
    logic                  user_pend;

    logic [DATA_BITS-1:0]  out_tdata;
    logic                  out_tuser;
    logic                  out_tlast;
    logic                  out_tvalid;

    assign in_window = (x_cnt >= x_start) && (x_cnt <= x_end);
    assign accept    = s_stream.tvalid && s_stream.tready;

    // column counter and the held frame-start bit.
    always_ff @(posedge s_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            x_cnt     <= '0;
            user_pend <= 1'b0;
        end else if (accept) begin
            x_cnt <= s_stream.tlast ? '0 : x_cnt + 1'b1;
            if (in_window) begin
                user_pend <= 1'b0;
            end else if (s_stream.tuser) begin
                user_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge s_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            out_tvalid <= 1'b0;
        end else if (s_stream.tready) begin
            out_tvalid <= s_stream.tvalid && in_window;
        end
    end

    // the payload loads whenever the stage advances.
    always_ff @(posedge s_axi4s) begin
        if (s_stream.tready) begin
            out_tdata <= s_stream.tdata;
            out_tuser <= s_stream.tuser || user_pend;
            out_tlast <= s_stream.tlast || (x_cnt == x_end);
        end
    end

    assign s_stream.tready = !m_stream.tvalid || m_stream.tready;

    assign m_stream.tdata  = out_tdata;
    assign m_stream.tuser  = out_tuser;
    assign m_stream.tlast  = out_tlast;
    assign m_stream.tvalid = out_tvalid;

    // a stalled beat stays put until the row stage takes it.
    stall_hold: assert property (
        @(posedge s_axi4s) disable iff (!rst_n)
        m_stream.tvalid && !m_stream.tready |=>
            m_stream.tvalid && $stable(m_stream.tdata) &&
            $stable(m_stream.tuser) && $stable(m_stream.tlast)
    );

endmodule

// File: project.f
trim_pkg.sv
axi4s_if.sv
trim_config.sv
line_trimming.sv
row_trimming.sv
image_trimming.sv
tb_clock_gen.sv
tb_image_trimming.sv

// File: row_trimming.sv
/*
 * Vertical crop stage.
 * Counts lines, keeps rows y_start to y_end and places the frame-start
 * bit on the first kept pixel of row y_start.
 */

module row_trimming
    import trim_pkg::*;
#(
    parameter int COORD_BITS = DEF_COORD_BITS,
    parameter int DATA_BITS  = DEF_DATA_BITS
) (
    input  logic                  s_axi4s,
    input  logic                  rst_n,
    input  logic [COORD_BITS-1:0] y_start,
    input  logic [COORD_BITS-1:0] y_end,
    axi4s_if.snk                  s_stream,
    axi4s_if.src                  m_stream
);

    logic [COORD_BITS-1:0] y_cnt;
    logic [COORD_BITS-1:0] cur_row;
    logic                  first_px;
    logic                  line_head;
    logic                  keep;
    logic                  accept;

    logic [DATA_BITS-1:0]  out_tdata;
    logic                  out_tuser;
    logic                  out_tlast;
    logic                  out_tvalid;

    // a frame-start beat is always row 0 and always the head of a line.
    assign cur_row   = s_stream.tuser ? '0 : y_cnt;
    assign line_head = first_px || s_stream.tuser;
    assign keep      = s_stream.tvalid && (cur_row >= y_start) && (cur_row <= y_end);
    assign accept    = s_stream.tvalid && s_stream.tready;

    always_ff @(posedge s_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            y_cnt    <= '0;
            first_px <= 1'b1;
        end else if (accept) begin
            y_cnt    <= s_stream.tlast ? cur_row + 1'b1 : cur_row;
            first_px <= s_stream.tlast;
        end
    end

    always_ff @(posedge s_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            out_tvalid <= 1'b0;
            out_tuser  <= 1'b0;
        end else if (s_stream.tready) begin
            out_tvalid <= keep;
            out_tuser  <= keep && line_head && (cur_row == y_start);
        end
    end

    always_ff @(posedge s_axi4s) begin
        if (s_stream.tready) begin
            out_tdata <= s_stream.tdata;
            out_tlast <= s_stream.tlast;
        end
    end

    assign s_stream.tready = !m_stream.tvalid || m_stream.tready;

    assign m_stream.tdata  = out_tdata;
    assign m_stream.tuser  = out_tuser;
    assign m_stream.tlast  = out_tlast;
    assign m_stream.tvalid = out_tvalid;

    user_needs_valid: assert property (
        @(posedge s_axi4s) disable iff (!rst_n)
        m_stream.tuser |-> m_stream.tvalid
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the image cropping testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_image_trimming -f project.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * 20 ns clock, active-low reset held for two cycles.
 */

module tb_clock_gen (
    output logic s_axi4s,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 10ns;

    initial begin
        s_axi4s = 1'b0;
        forever #(HALF_PERIOD) s_axi4s = ~s_axi4s;
    end

    // release on a falling edge, clear of the active clock edge.
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge s_axi4s);
        @(negedge s_axi4s);
        rst_n = 1'b1;
    end

endmodule

// File: tb_image_trimming.sv
/*
 * Testbench of the image cropping subsystem.
 * Frame driver, config host, reference crop model, output checker, timeout.
 */

module tb_image_trimming
    import trim_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int COORD_BITS  = DEF_COORD_BITS;
    localparam int DATA_BITS   = DEF_DATA_BITS;
    localparam int FRAME_W     = 12;
    localparam int FRAME_H     = 8;
    localparam int NUM_FRAMES  = 8;
    localparam int CYCLE_LIMIT = 20 * NUM_FRAMES * FRAME_W * FRAME_H;
    localparam int DRAIN_LIMIT = 2 * FRAME_W * FRAME_H;
    localparam int COORD_MAX   = (1 << COORD_BITS) - 1;

    logic                  s_axi4s;
    logic                  rst_n;
    logic [DATA_BITS-1:0]  s_tdata = '0;
    logic                  s_tuser = 1'b0;
    logic                  s_tlast = 1'b0;
    logic                  s_tvalid = 1'b0;
    logic                  s_tready;
    logic [DATA_BITS-1:0]  m_tdata;
    logic                  m_tuser;
    logic                  m_tlast;
    logic                  m_tvalid;
    logic                  m_tready = 1'b1;
    logic                  cfg_req = 1'b0;
    trim_op_e              cfg_op = OP_X_START;
    logic [COORD_BITS-1:0] cfg_data = '0;
    logic                  cfg_ack;

    int  seed = 98553;
    bit  random_ready = 1'b0;
    int  cycle_count = 0;

    // host-side model of the staged and active window.
    int  stg_x_start = 0;
    int  stg_x_end   = COORD_MAX;
    int  stg_y_start = 0;
    int  stg_y_end   = COORD_MAX;
    int  act_x_start = 0;
    int  act_x_end   = COORD_MAX;
    int  act_y_start = 0;
    int  act_y_end   = COORD_MAX;

    // each entry is {user, last, data}.
    logic [DATA_BITS+1:0] expected_q[$];
    logic [DATA_BITS+1:0] exp_beat;

    tb_clock_gen u_clock (
        .s_axi4s (s_axi4s),
        .rst_n   (rst_n)
    );

    image_trimming #(
        .COORD_BITS(COORD_BITS),
        .DATA_BITS (DATA_BITS)
    ) DUT (
        .s_axi4s  (s_axi4s),
        .rst_n    (rst_n),
        .s_tdata  (s_tdata),
        .s_tuser  (s_tuser),
        .s_tlast  (s_tlast),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_tdata  (m_tdata),
        .m_tuser  (m_tuser),
        .m_tlast  (m_tlast),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .cfg_req  (cfg_req),
        .cfg_op   (cfg_op),
        .cfg_data (cfg_data),
        .cfg_ack  (cfg_ack)
    );

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic report_error(input string why);
        $display("%0t ns: %s", $time, why);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    // expected output beat for one input pixel; returns 0 when it is cropped.
    function automatic bit crop_ref(input int row, input int col,
                                    output logic [DATA_BITS+1:0] beat);
        int x_hi;
        int y_hi;
        x_hi = (act_x_end < FRAME_W - 1) ? act_x_end : FRAME_W - 1;
        y_hi = (act_y_end < FRAME_H - 1) ? act_y_end : FRAME_H - 1;
        beat = {(row == act_y_start) && (col == act_x_start), col == x_hi,
                DATA_BITS'(row * 16 + col)};
        return (row >= act_y_start) && (row <= y_hi) &&
               (col >= act_x_start) && (col <= x_hi);
    endfunction

    // one four-phase transfer; ack must follow req by exactly one cycle each way.
    task automatic cfg_write(input trim_op_e op, input int value);
        cfg_op   = op;
        cfg_data = COORD_BITS'(value);
        cfg_req  = 1'b1;
        check_value("cfg_ack", 32'(cfg_ack), 32'd0);
        @(negedge s_axi4s);
        check_value("cfg_ack", 32'(cfg_ack), 32'd1);
        cfg_req = 1'b0;
        @(negedge s_axi4s);
        check_value("cfg_ack", 32'(cfg_ack), 32'd0);
        case (op)
            OP_X_START: stg_x_start = value;
            OP_X_END:   stg_x_end   = value;
            OP_Y_START: stg_y_start = value;
            OP_Y_END:   stg_y_end   = value;
            OP_APPLY: begin
                act_x_start = stg_x_start;
                act_x_end   = stg_x_end;
                act_y_start = stg_y_start;
                act_y_end   = stg_y_end;
            end
            default: ;
        endcase
    endtask

    task automatic set_window(input int x0, input int x1, input int y0, input int y1);
        cfg_write(OP_X_START, x0);
        cfg_write(OP_X_END, x1);
        cfg_write(OP_Y_START, y0);
        cfg_write(OP_Y_END, y1);
        cfg_write(OP_APPLY, 0);
    endtask

    task automatic send_frame();
        logic [DATA_BITS+1:0] beat;
        bit accepted;
        int row;
        int col;
        for (row = 0; row < FRAME_H; row++) begin
            for (col = 0; col < FRAME_W; col++) begin
                if (crop_ref(row, col, beat)) begin
                    expected_q.push_back(beat);
                end
            end
        end
        for (row = 0; row < FRAME_H; row++) begin
            for (col = 0; col < FRAME_W; col++) begin
                s_tdata  = DATA_BITS'(row * 16 + col);
                s_tuser  = (row == 0) && (col == 0);
                s_tlast  = (col == FRAME_W - 1);
                s_tvalid = 1'b1;
                do begin
                    @(posedge s_axi4s);
                    accepted = s_tready;
                    @(negedge s_axi4s);
                end while (!accepted);
            end
        end
        s_tvalid = 1'b0;
        s_tuser  = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // let the pipeline empty before the window changes.
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge s_axi4s);
            waited++;
        end
        repeat (4) @(negedge s_axi4s);
        if (expected_q.size() != 0) begin
            report_error($sformatf("%0d expected beats never arrived", expected_q.size()));
        end
    endtask

    always @(negedge s_axi4s) begin
        m_tready = random_ready ? 1'($random(seed)) : 1'b1;
    end

    always @(posedge s_axi4s) begin
        if (rst_n && m_tvalid && m_tready) begin
            if (expected_q.size() == 0) begin
                report_error("an output beat arrived with no expected beat left");
            end else begin
                exp_beat = expected_q.pop_front();
                check_value("m_tdata", 32'(m_tdata), 32'(exp_beat[DATA_BITS-1:0]));
                check_value("m_tlast", 32'(m_tlast), 32'(exp_beat[DATA_BITS]));
                check_value("m_tuser", 32'(m_tuser), 32'(exp_beat[DATA_BITS+1]));
            end
        end
    end

    always @(posedge s_axi4s) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            report_error($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        wait (rst_n === 1'b1);
        @(negedge s_axi4s);
        check_value("m_tvalid", 32'(m_tvalid), 32'd0);
        check_value("cfg_ack", 32'(cfg_ack), 32'd0);

        // full frames pass unchanged out of reset.
        send_frame();
        send_frame();
        wait_drain();

        // staged values alone must not touch the active window.
        cfg_write(OP_X_START, 2);
        cfg_write(OP_X_END, 10);
        cfg_write(OP_Y_START, 3);
        cfg_write(OP_Y_END, 4);
        send_frame();
        wait_drain();
        cfg_write(OP_APPLY, 0);
        send_frame();
        wait_drain();

        set_window(3, 7, 0, COORD_MAX);
        send_frame();
        wait_drain();

        set_window(0, 11, 2, 5);
        send_frame();
        wait_drain();

        // combined crop with back-pressure from the sink.
        set_window(4, 9, 1, 6);
        random_ready = 1'b1;
        send_frame();
        send_frame();
        wait_drain();
        random_ready = 1'b0;

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: trim_config.sv
/*
 * Configuration port of the cropping window.
 * Four-phase req/ack handshake, staged and active window registers.
 */

module trim_config
    import trim_pkg::*;
#(
    parameter int COORD_BITS = DEF_COORD_BITS
) (
    input  logic                  s_axi4s,
    input  logic                  rst_n,
    input  logic                  cfg_req,
    input  trim_op_e              cfg_op,
    input  logic [COORD_BITS-1:0] cfg_data,
    output logic                  cfg_ack,
    output logic [COORD_BITS-1:0] x_start,
    output logic [COORD_BITS-1:0] x_end,
    output logic [COORD_BITS-1:0] y_start,
    output logic [COORD_BITS-1:0] y_end
);

    cfg_state_e            state;

    logic [COORD_BITS-1:0] stg_x_start;
    logic [COORD_BITS-1:0] stg_x_end;
    logic [COORD_BITS-1:0] stg_y_start;
    logic [COORD_BITS-1:0] stg_y_end;

    // a request is executed once, on the edge that moves the FSM into CFG_ACK.
    // the window opens to the full frame after reset.
    always_ff @(posedge s_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            state       <= CFG_IDLE;
            stg_x_start <= '0;
            stg_x_end   <= '1;
            stg_y_start <= '0;
            stg_y_end   <= '1;
            x_start     <= '0;
            x_end       <= '1;
            y_start     <= '0;
            y_end       <= '1;
        end else begin
            case (state)
                CFG_IDLE: begin
                    if (cfg_req) begin
                        state <= CFG_ACK;
                        case (cfg_op)
                            OP_X_START: stg_x_start <= cfg_data;
                            OP_X_END:   stg_x_end   <= cfg_data;
                            OP_Y_START: stg_y_start <= cfg_data;
                            OP_Y_END:   stg_y_end   <= cfg_data;
                            OP_APPLY: begin
                                // all four move together so the stages never
                                // see a half-updated window.
                                x_start <= stg_x_start;
                                x_end   <= stg_x_end;
                                y_start <= stg_y_start;
                                y_end   <= stg_y_end;
                            end
                            default: ;
                        endcase
                    end
                end
                CFG_ACK: begin
                    if (!cfg_req) begin
                        state <= CFG_IDLE;
                    end
                end
                default: state <= CFG_IDLE;
            endcase
        end
    end

    assign cfg_ack = (state == CFG_ACK);

    // ack only ever answers a request seen on the previous edge.
    ack_follows_req: assert property (
        @(posedge s_axi4s) disable iff (!rst_n)
        $rose(cfg_ack) |-> $past(cfg_req)
    );

endmodule

// File: trim_pkg.sv
/*
 * Shared definitions for the image cropping subsystem.
 * Configuration opcodes, the config handshake states and default widths.
 */

package trim_pkg;

    // default widths, used as the parameter defaults of the top level.
    localparam int DEF_COORD_BITS = 11;
    localparam int DEF_DATA_BITS  = 8;

    // operations accepted on the configuration port.
    typedef enum logic [2:0] {
        OP_X_START = 3'd0,
        OP_X_END   = 3'd1,
        OP_Y_START = 3'd2,
        OP_Y_END   = 3'd3,
        OP_APPLY   = 3'd4
    } trim_op_e;

    // four-phase handshake state of the configuration port.
    typedef enum logic {
        CFG_IDLE = 1'b0,
        CFG_ACK  = 1'b1
    } cfg_state_e;

endpackage
